/* filelist.f */
+incdir+common
+incdir+bench
common/ilk_pkg.sv
lane_tx/ilk_lane_fifo.sv
lane_tx/ilk_lane_tx.sv
tx_datapath/ilk_tx_datapath.sv
rtl/ilk_tx_top.sv
bench/ilk_tx_tb.sv

/* bench/ilk_tx_model.svh */
`ifndef ILK_TX_MODEL_SVH
`define ILK_TX_MODEL_SVH

localparam int ROW_SOP = 0; // burst control row that opens a packet
localparam int ROW_DATA = 1;
localparam int ROW_EOP = 2; // burst control row that closes a packet
localparam logic [65:0] IDLE_BLOCK = {`ILK_HDR_CTRL, `ILK_IDLE_PATTERN};

// receiver side of x^58 + x^39 + 1, msbit first
// the line bits feed the history, the new history sits above the clear payload
function automatic logic [121:0] descramble(input logic [57:0] hist, input logic [63:0] d);
	logic [57:0] s;
	logic [63:0] o;
	s = hist;
	for (int b = 63; b >= 0; b--)
	begin
		o[b] = d[b] ^ s[57] ^ s[38];
		s = {s[56:0], d[b]};
	end
	return {s, o};
endfunction

// a row of fill, every lane an idle control block
function automatic bit row_is_idle(input logic [66*`ILK_NUM_LANES-1:0] r);
	bit idle;
	idle = 1'b1;
	for (int l = 0; l < `ILK_NUM_LANES; l++)
	begin
		if (r[66*(`ILK_NUM_LANES-l)-1 -: 66] != IDLE_BLOCK)
			idle = 1'b0;
	end
	return idle;
endfunction

// clear row that one row of an accepted beat should produce, lane 0 on top
function automatic logic [66*`ILK_NUM_LANES-1:0] expected_row(input tx_beat_t b, input int kind);
	logic [66*`ILK_NUM_LANES-1:0] r;
	ctrl_word_t cw;
	cw = '0;
	cw.code = `ILK_CTRL_BURST;
	cw.chan = b.chan; // both control rows name the channel
	cw.sop = (kind == ROW_SOP);
	cw.eop = (kind == ROW_EOP);
	cw.eop_bytes = (kind == ROW_EOP) ? b.eop_bytes : 3'd0;
	for (int l = 0; l < `ILK_NUM_LANES; l++)
	begin
		r[66*(`ILK_NUM_LANES-l)-1 -: 66] = IDLE_BLOCK; // unused lanes idle
		if (kind == ROW_DATA && l < b.num_words)
			r[66*(`ILK_NUM_LANES-l)-1 -: 66] = {`ILK_HDR_DATA, b.data[l]};
		else if (kind != ROW_DATA && l == 0)
			r[66*(`ILK_NUM_LANES-l)-1 -: 66] = {`ILK_HDR_CTRL, cw};
	end
	return r;
endfunction

`endif

/* bench/ilk_tx_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ilk_params.svh"

module ilk_tx_tb
	import ilk_pkg::*;
();

	localparam int ROW_W = 66*`ILK_NUM_LANES;
	localparam int NUM_PKTS = 40;
	localparam int IDLE_START = 70; // covers a second sync slot before any traffic
	localparam int IDLE_END = 80;

	logic clk;
	logic rst_n;
	tx_beat_t beat;
	logic valid;
	logic ack;
	logic [ROW_W-1:0] tx_data;

	integer seed;
	tx_beat_t beat_q[$]; // every beat of the run, built before reset is released
	int gaps[$]; // idle cycles before each beat
	logic [ROW_W-1:0] exp_q[$];
	logic [ROW_W-1:0] got_q[$]; // descrambled rows that still wait for the compare
	logic [57:0] dscr [`ILK_NUM_LANES]; // descrambler history of each lane
	logic out_live = 1'b0; // tx_data holds a block counted from reset
	int blk_idx = 0;
	int cycles = 0;
	int limit = 0;
	int stalls = 0; // falling edges a beat had to wait for ack

	`include "ilk_tx_model.svh"

	ilk_tx_top u_dut (
		.clk(clk),
		.rst_n(rst_n),
		.beat(beat),
		.valid(valid),
		.ack(ack),
		.tx_data(tx_data)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TEST FAIL");
		$fatal(1, "run stopped");
	endtask

	task automatic check_value(input string name, input logic [ROW_W-1:0] got,
		input logic [ROW_W-1:0] exp);
		if (got !== exp)
			abort_run($sformatf("ERR %0t %s got %h expected %h", $time, name, got, exp));
	endtask

	// random packets, short last beats, mostly no gap so control rows stall the input
	task automatic build_packets();
		tx_beat_t b;
		int len;
		int g;
		for (int p = 0; p < NUM_PKTS; p++)
		begin
			len = 1 + ($unsigned($random(seed)) % 6);
			b.chan = 8'($random(seed));
			for (int k = 0; k < len; k++)
			begin
				for (int w = 0; w < `ILK_BEAT_WORDS; w++)
					b.data[w] = {$random(seed), $random(seed)};
				b.sop = (k == 0);
				b.eop = (k == len - 1);
				b.num_words = b.eop ? 3'(1 + ($unsigned($random(seed)) % 4)) : 3'd4;
				b.eop_bytes = b.eop ? 3'($random(seed)) : 3'd0;
				beat_q.push_back(b);
				g = $unsigned($random(seed)) % 8;
				gaps.push_back((g > 3) ? 0 : g);
			end
		end
	endtask

	// called on a falling edge, ack only moves on rising edges so it is settled here
	task automatic send_beat(input tx_beat_t b);
		beat = b;
		valid = 1'b1;
		while (!ack)
		begin
			stalls++; // input buffer full while control rows go out
			@(negedge clk);
		end
		if (b.sop)
			exp_q.push_back(expected_row(b, ROW_SOP));
		exp_q.push_back(expected_row(b, ROW_DATA));
		if (b.eop)
			exp_q.push_back(expected_row(b, ROW_EOP));
		@(negedge clk); // the beat is taken on the rising edge in between
	endtask

	initial
	begin : main
		int total_rows;
		int total_gaps;
		seed = 32'h1f77;
		rst_n = 1'b0;
		valid = 1'b0;
		beat = '0;
		for (int l = 0; l < `ILK_NUM_LANES; l++)
			dscr[l] = `ILK_SCR_SEED(l);
		build_packets();
		total_rows = 0;
		total_gaps = 0;
		foreach (beat_q[i])
		begin
			total_rows += 1 + beat_q[i].sop + beat_q[i].eop;
			total_gaps += gaps[i];
		end
		// four cycles per row at worst, one sync slot per metaframe, then a margin
		limit = 8 + IDLE_START + IDLE_END + total_gaps + 4*total_rows
			+ 4*total_rows/`ILK_MFRAME_LEN + 100;
		for (int c = 0; c < 8; c++)
		begin
			@(negedge clk);
			check_value("ack", ack, '0); // no beat may be taken while reset is held
		end
		rst_n = 1'b1;
		repeat (IDLE_START) @(negedge clk);
		foreach (beat_q[i])
		begin
			if (gaps[i] > 0)
			begin
				valid = 1'b0;
				repeat (gaps[i]) @(negedge clk);
			end
			send_beat(beat_q[i]);
		end
		valid = 1'b0;
		while (exp_q.size() != 0)
			@(negedge clk);
		repeat (IDLE_END) @(negedge clk); // only idles and syncs may show up now
		if (stalls == 0)
			abort_run("ack never dropped, the input back-pressure was never exercised");
		else
		begin
			$display("TEST PASS");
			$finish;
		end
	end

	always @(posedge clk)
	begin
		out_live <= rst_n; // the block after the first edge out of reset is a sync
		cycles <= cycles + 1;
		if (limit != 0 && cycles >= limit)
			abort_run($sformatf("output rows stopped arriving, %0d expected rows still missing",
				exp_q.size()));
	end

	// all lanes share one block position, sync slots are checked and skipped
	always @(negedge clk)
	begin : lane_monitor
		logic [65:0] blk;
		logic [121:0] res;
		logic [ROW_W-1:0] clear_row;
		if (out_live)
		begin
			for (int l = 0; l < `ILK_NUM_LANES; l++)
			begin
				blk = tx_data[66*(`ILK_NUM_LANES-l)-1 -: 66];
				if (blk_idx % `ILK_MFRAME_LEN == 0)
					check_value($sformatf("lane%0d sync block", l), blk,
						{`ILK_HDR_CTRL, `ILK_SYNC_PATTERN});
				else
				begin
					res = descramble(dscr[l], blk[63:0]);
					dscr[l] = res[121:64];
					clear_row[66*(`ILK_NUM_LANES-l)-1 -: 66] = {blk[65:64], res[63:0]};
				end
			end
			if (blk_idx % `ILK_MFRAME_LEN != 0 && !row_is_idle(clear_row))
				got_q.push_back(clear_row); // idle fill carries nothing to compare
			blk_idx++;
		end
	end

	always @(posedge clk)
	begin : compare_rows
		logic [ROW_W-1:0] got;
		while (got_q.size() != 0)
		begin
			got = got_q.pop_front();
			if (exp_q.size() == 0)
				abort_run($sformatf("a row arrived that no accepted beat asked for: %h", got));
			else
				check_value("tx_data row", got, exp_q.pop_front());
		end
	end

endmodule

`default_nettype wire

/* rtl/ilk_tx_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ilk_params.svh"

module ilk_tx_top
	import ilk_pkg::*;
(
	input wire clk,
	input wire rst_n,
	input wire tx_beat_t beat, // user beat, held until ack
	input wire valid,
	output logic ack,
	output logic [66*`ILK_NUM_LANES-1:0] tx_data // lane 0 in the top 66 bits
);

	lane_word_t [0:`ILK_NUM_LANES-1] row; // one word for each lane, row[0] is lane 0
	logic row_valid;
	logic [`ILK_NUM_LANES-1:0] lane_ack; // fifo space per lane

	ilk_tx_datapath u_datapath (
		.clk(clk),
		.rst_n(rst_n),
		.beat(beat),
		.valid(valid),
		.ack(ack),
		.row(row),
		.row_valid(row_valid),
		.lane_ack(lane_ack)
	);

	// lane i drives the i-th 66-bit field counted from the top
	genvar i;
	generate
		for (i = 0; i < `ILK_NUM_LANES; i = i + 1)
		begin : g_lane
			ilk_lane_tx #(
				.LANE_INDEX(i) // picks the scrambler seed
			) u_lane (
				.clk(clk),
				.rst_n(rst_n),
				.din(row[i]),
				.din_valid(row_valid),
				.din_ack(lane_ack[i]),
				.block(tx_data[66*(`ILK_NUM_LANES-i)-1 -: 66])
			);
		end
	endgenerate

endmodule

`default_nettype wire

/* tx_datapath/ilk_tx_datapath.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ilk_params.svh"

module ilk_tx_datapath
	import ilk_pkg::*;
(
	input wire clk,
	input wire rst_n,
	input wire tx_beat_t beat,
	input wire valid,
	output logic ack, // from registered state only
	output lane_word_t [0:`ILK_NUM_LANES-1] row,
	output logic row_valid, // row is taken by every lane on this edge
	input wire [`ILK_NUM_LANES-1:0] lane_ack
);

	// which row of the head beat goes out next
	typedef enum logic [1:0]
	{
		PH_HEAD, // fresh head beat, sop decides the first row
		PH_SOP, // burst control row with sop
		PH_DATA, // the data words
		PH_EOP // burst control row with eop
	} phase_t;

	phase_t phase_q; // PH_SOP never lands here, it is always followed by data
	phase_t cur_phase;
	logic ready_q; // low through reset, so ack stays low there
	tx_beat_t head; // oldest beat in the input buffer
	logic in_full;
	logic in_empty;
	logic in_pop;
	logic all_ack;
	ctrl_word_t cw;

	ilk_lane_fifo #(
		.T(tx_beat_t),
		.DEPTH(2)
	) u_in_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.wr_data(beat),
		.wr_en(valid & ack),
		.full(in_full),
		.rd_data(head),
		.rd_en(in_pop),
		.empty(in_empty)
	);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			ready_q <= 1'b0;
		else
			ready_q <= 1'b1;
	end

	assign ack = ready_q & ~in_full; // no dependence on valid
	assign all_ack = &lane_ack; // lanes must stay row aligned, so all or none
	assign row_valid = ~in_empty & all_ack;

	// a beat without sop skips straight to its data row
	assign cur_phase = (phase_q == PH_HEAD) ? (head.sop ? PH_SOP : PH_DATA) : phase_q;

	// the beat leaves the buffer with its last row
	assign in_pop = row_valid & ((cur_phase == PH_EOP) | (cur_phase == PH_DATA & ~head.eop));

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			phase_q <= PH_HEAD;
		else if (row_valid)
		begin
			case (cur_phase)
				PH_SOP: phase_q <= PH_DATA;
				PH_DATA: phase_q <= head.eop ? PH_EOP : PH_HEAD;
				default: phase_q <= PH_HEAD; // eop row done, next beat
			endcase
		end
	end

	// control word for lane 0, the sop and eop marks are picked per phase
	always_comb
	begin
		cw = '0;
		cw.code = `ILK_CTRL_BURST;
		cw.chan = head.chan; // channel is repeated in the eop row as well
		cw.sop = (cur_phase == PH_SOP);
		cw.eop = (cur_phase == PH_EOP);
		cw.eop_bytes = (cur_phase == PH_EOP) ? head.eop_bytes : 3'd0;
	end

	always_comb
	begin
		for (int i = 0; i < `ILK_NUM_LANES; i++)
		begin
			row[i].ctrl = 1'b1; // idle control word unless replaced below
			row[i].payload = `ILK_IDLE_PATTERN;
			if (cur_phase == PH_DATA)
			begin
				if (i < int'(head.num_words)) // short beats leave the top lanes idle
				begin
					row[i].ctrl = 1'b0;
					row[i].payload = head.data[i];
				end
			end
			else if (i == 0)
				row[i].payload = cw; // burst control rides on lane 0 only
		end
	end

	// the lanes fill and drain in step, so their fifos run full together or not at all
	a_lanes_aligned: assert property (@(posedge clk) disable iff (!rst_n)
		(lane_ack == '0) || all_ack);

	// an empty beat would produce a data row with no data at all
	a_beat_not_empty: assert property (@(posedge clk) disable iff (!rst_n)
		(valid && ack) |-> (beat.num_words != 3'd0 && beat.num_words <= `ILK_BEAT_WORDS));

endmodule

`default_nettype wire

/* lane_tx/ilk_lane_tx.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ilk_params.svh"

module ilk_lane_tx
	import ilk_pkg::*;
#(
	parameter int LANE_INDEX = 0
)
(
	input wire clk,
	input wire rst_n,
	input wire lane_word_t din,
	input wire din_valid,
	output logic din_ack, // room for one more word
	output logic [65:0] block // header in bits 65:64, payload below
);

	localparam int CNT_W = $clog2(`ILK_MFRAME_LEN);
	localparam logic [57:0] SEED = `ILK_SCR_SEED(LANE_INDEX);

	// self-synchronous scrambler, x^58 + x^39 + 1, msbit first
	// returns the next state on top of the scrambled word
	function automatic logic [121:0] scramble(input logic [57:0] st, input logic [63:0] d);
		logic [57:0] s;
		logic [63:0] o;
		s = st;
		for (int b = 63; b >= 0; b--)
		begin
			o[b] = d[b] ^ s[57] ^ s[38];
			s = {s[56:0], o[b]}; // the line bit feeds back, so the receiver can self sync
		end
		return {s, o};
	endfunction

	logic [CNT_W-1:0] blk_cnt_q; // position inside the metaframe
	logic [57:0] scr_q;
	lane_word_t head;
	lane_word_t sel; // word chosen for this block before scrambling
	logic fifo_full;
	logic fifo_empty;
	logic is_sync;
	logic pop;
	logic [121:0] scr_out;

	ilk_lane_fifo #(
		.T(lane_word_t),
		.DEPTH(`ILK_FIFO_DEPTH)
	) u_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.wr_data(din),
		.wr_en(din_valid & ~fifo_full),
		.full(fifo_full),
		.rd_data(head),
		.rd_en(pop),
		.empty(fifo_empty)
	);

	assign din_ack = ~fifo_full;

	assign is_sync = (blk_cnt_q == '0);
	assign pop = ~is_sync & ~fifo_empty; // all lanes hold the same row count, so they pop together

	always_comb
	begin
		if (is_sync)
			sel = '{ctrl: 1'b1, payload: `ILK_SYNC_PATTERN};
		else if (!fifo_empty)
			sel = head;
		else
			sel = '{ctrl: 1'b1, payload: `ILK_IDLE_PATTERN}; // nothing queued, fill with idle
	end

	assign scr_out = scramble(scr_q, sel.payload);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			blk_cnt_q <= '0; // first block out of reset is sync on every lane
			scr_q <= SEED;
		end
		else
		begin
			blk_cnt_q <= (blk_cnt_q == CNT_W'(`ILK_MFRAME_LEN - 1)) ? '0 : blk_cnt_q + 1'b1;
			if (!is_sync)
				scr_q <= scr_out[121:64]; // sync blocks bypass the scrambler and leave it alone
		end
	end

	always_ff @(posedge clk)
	begin
		block[65:64] <= sel.ctrl ? `ILK_HDR_CTRL : `ILK_HDR_DATA;
		block[63:0] <= is_sync ? sel.payload : scr_out[63:0];
	end

	// the datapath only writes in a cycle where every lane acks
	a_no_write_full: assert property (@(posedge clk) disable iff (!rst_n)
		din_valid |-> !fifo_full);

endmodule

`default_nettype wire

/* lane_tx/ilk_lane_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module ilk_lane_fifo #(
	parameter type T = logic,
	parameter int DEPTH = 4
)
(
	input wire clk,
	input wire rst_n,
	input wire T wr_data,
	input wire wr_en,
	output logic full,
	output T rd_data, // head entry, valid while not empty
	input wire rd_en,
	output logic empty
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	T mem [DEPTH]; // storage has no reset, only the pointers do
	logic [AW-1:0] wr_ptr_q;
	logic [AW-1:0] rd_ptr_q;
	logic [AW:0] count_q; // one extra bit so full and empty differ

	assign full = (count_q == (AW+1)'(DEPTH));
	assign empty = (count_q == '0);
	assign rd_data = mem[rd_ptr_q];

	always_ff @(posedge clk)
	begin
		if (wr_en)
			mem[wr_ptr_q] <= wr_data;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q <= '0;
		end
		else
		begin
			if (wr_en)
				wr_ptr_q <= (wr_ptr_q == AW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1; // depth need not be a power of two
			if (rd_en)
				rd_ptr_q <= (rd_ptr_q == AW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
			count_q <= count_q + (wr_en ? 1'b1 : 1'b0) - (rd_en ? 1'b1 : 1'b0);
		end
	end

	// callers are expected to look at empty and full first
	a_no_read_empty: assert property (@(posedge clk) disable iff (!rst_n) rd_en |-> !empty);
	a_no_write_full: assert property (@(posedge clk) disable iff (!rst_n) wr_en |-> !full);

endmodule

`default_nettype wire

/* common/ilk_pkg.sv */
`default_nettype none

package ilk_pkg;

`include "ilk_params.svh"

	// one lane entry as it travels from the datapath into a lane fifo
	typedef struct packed
	{
		logic ctrl; // set for a control word, sets the block header
		logic [63:0] payload;
	} lane_word_t;

	// layout of a 64-bit control payload, type code in the top bits
	typedef struct packed
	{
		logic [1:0] code; // burst or idle
		logic sop; // packet starts after this word
		logic eop; // packet ended before this word
		logic [2:0] eop_bytes; // valid bytes in the last data word, 0 means all eight
		logic [7:0] chan; // channel of the burst
		logic [48:0] pad; // sent as zero
	} ctrl_word_t;

	// one user beat
	typedef struct packed
	{
		logic [0:`ILK_BEAT_WORDS-1][63:0] data; // data[0] is the most significant word
		logic [2:0] num_words; // valid words counted from data[0], 1 to 4
		logic [7:0] chan;
		logic sop;
		logic eop;
		logic [2:0] eop_bytes; // byte count of the last valid word
	} tx_beat_t;

endpackage

`default_nettype wire

/* common/ilk_params.svh */
`ifndef ILK_PARAMS_SVH
`define ILK_PARAMS_SVH

`define ILK_NUM_LANES 4 // lanes striped by the datapath
`define ILK_BEAT_WORDS 4 // user words per beat, most significant word first
`define ILK_FIFO_DEPTH 8 // entries in each lane fifo
`define ILK_MFRAME_LEN 64 // blocks per metaframe, the first one is the sync block

`define ILK_HDR_DATA 2'b01 // block header for a data payload
`define ILK_HDR_CTRL 2'b10 // block header for a control payload

`define ILK_CTRL_BURST 2'b11 // type code of a burst control word
`define ILK_CTRL_IDLE 2'b01 // type code of an idle control word

`define ILK_SYNC_PATTERN 64'h78f6_78f6_78f6_78f6 // sent in the clear
`define ILK_IDLE_PATTERN {`ILK_CTRL_IDLE, 62'h0} // idle type code, all other fields zero

// each lane starts its scrambler somewhere else so the lanes do not look alike
`define ILK_SCR_SEED(idx) (58'h1a5_c3e7_0b92_d64f + 58'(24'h9e3b71 * (idx)))

`endif
